//--- logic/wb_burst_adr.sv
`timescale 1ns/10ps

module wb_burst_adr (
  input  logic [wb_upsizer_pkg::AW-1:0] adr_i,
  input  logic [2:0]                    cti_i,
  input  logic [1:0]                    bte_i,
  input  logic                          cyc_i,
  output logic [wb_upsizer_pkg::AW-1:0] next_wide_adr_o,
  output logic                          last_beat_o,
  output logic                          last_in_batch_o
);

  // Narrow address of the following beat
  logic [wb_upsizer_pkg::AW-1:0] next_narrow;
  // Wide word holding the current beat
  logic [wb_upsizer_pkg::AW-1:0] cur_wide;

  //////////////////////////////////////////////////
  // Address stepping
  //////////////////////////////////////////////////

  // Step at narrow width, wrap lines counted in narrow beats
  assign next_narrow = wb_upsizer_pkg::next_adr(adr_i, cti_i, bte_i,
                                                wb_upsizer_pkg::DW_IN / 8);

  // Reduce both to wide word addresses
  assign next_wide_adr_o = next_narrow >> wb_upsizer_pkg::WIDE_SHIFT;
  assign cur_wide        = adr_i >> wb_upsizer_pkg::WIDE_SHIFT;

  //////////////////////////////////////////////////
  // End conditions
  //////////////////////////////////////////////////

  // Classic cycle or end-of-burst closes the transfer
  assign last_beat_o = cyc_i &
                       ((cti_i == wb_upsizer_pkg::CTI_CLASSIC) |
                        (cti_i == wb_upsizer_pkg::CTI_EOB));

  // Batch ends when the burst leaves this wide word
  // or the transfer ends
  assign last_in_batch_o = (next_wide_adr_o != cur_wide) | last_beat_o;

endmodule

//--- logic/wb_upsizer.sv
`timescale 1ns/10ps

module wb_upsizer (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  // Narrow slave port
  input  logic [wb_upsizer_pkg::AW-1:0]      wbs_adr_i,
  input  logic [wb_upsizer_pkg::DW_IN-1:0]   wbs_dat_i,
  input  logic [wb_upsizer_pkg::SEL_IN-1:0]  wbs_sel_i,
  input  logic                               wbs_we_i,
  input  logic                               wbs_cyc_i,
  input  logic                               wbs_stb_i,
  input  logic [2:0]                         wbs_cti_i,
  input  logic [1:0]                         wbs_bte_i,
  output logic [wb_upsizer_pkg::DW_IN-1:0]   wbs_dat_o,
  output logic                               wbs_ack_o,
  output logic                               wbs_err_o,
  // Wide master port
  output logic [wb_upsizer_pkg::AW-1:0]      wbm_adr_o,
  output logic [wb_upsizer_pkg::DW_OUT-1:0]  wbm_dat_o,
  output logic [wb_upsizer_pkg::SEL_OUT-1:0] wbm_sel_o,
  output logic                               wbm_we_o,
  output logic                               wbm_cyc_o,
  output logic                               wbm_stb_o,
  output logic [2:0]                         wbm_cti_o,
  output logic [1:0]                         wbm_bte_o,
  input  logic [wb_upsizer_pkg::DW_OUT-1:0]  wbm_dat_i,
  input  logic                               wbm_ack_i,
  input  logic                               wbm_err_i
);

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Address split of the current narrow beat
  logic [wb_upsizer_pkg::LANE_BITS-1:0]                      lane;
  logic [wb_upsizer_pkg::AW-wb_upsizer_pkg::WIDE_SHIFT-1:0]  cur_wadr;

  // From the burst address helper
  logic [wb_upsizer_pkg::AW-1:0] next_wide_adr;
  logic                          last_beat;
  logic                          last_in_batch;

  // One-hot FSM, all low means idle
  logic rd_pend;
  logic wr_pend;
  logic wr_gath;
  logic idle;

  // Gather side control
  logic wr_ack_q;
  logic wr_first;

  // Wide word address of the access on the wide bus
  logic [wb_upsizer_pkg::AW-wb_upsizer_pkg::WIDE_SHIFT-1:0] wadr_q;

  // Read buffer
  wb_upsizer_pkg::wide_word_u                               rbuf;
  logic [wb_upsizer_pkg::AW-wb_upsizer_pkg::WIDE_SHIFT-1:0] rbuf_adr;
  logic                                                     rbuf_vld;
  logic                                                     rbuf_hit;

  // Write gather buffer, selects kept per lane
  wb_upsizer_pkg::wide_word_u                                           wbuf;
  logic [wb_upsizer_pkg::SCALE-1:0][wb_upsizer_pkg::SEL_IN-1:0]         wsel;

  // Word the narrow read data is taken from
  wb_upsizer_pkg::wide_word_u rd_word;

  logic req;
  logic wr_capture;
  logic rd_miss;

  //////////////////////////////////////////////////
  // Beat decode
  //////////////////////////////////////////////////

  assign req      = wbs_cyc_i & wbs_stb_i;
  assign idle     = !(rd_pend | wr_pend | wr_gath);
  assign lane     = wbs_adr_i[wb_upsizer_pkg::NARROW_SHIFT +: wb_upsizer_pkg::LANE_BITS];
  assign cur_wadr = wbs_adr_i[wb_upsizer_pkg::AW-1:wb_upsizer_pkg::WIDE_SHIFT];

  // Buffer holds the word of this beat
  assign rbuf_hit = rbuf_vld & (rbuf_adr == cur_wadr);

  // New write beat, never the one being acked
  assign wr_capture = req & wbs_we_i & (idle | (wr_gath & !wr_ack_q));

  // Read that needs a wide access
  assign rd_miss = idle & req & !wbs_we_i & !rbuf_hit;

  wb_burst_adr u_burst_adr (
    .adr_i           (wbs_adr_i),
    .cti_i           (wbs_cti_i),
    .bte_i           (wbs_bte_i),
    .cyc_i           (wbs_cyc_i),
    .next_wide_adr_o (next_wide_adr),
    .last_beat_o     (last_beat),
    .last_in_batch_o (last_in_batch)
  );

  //////////////////////////////////////////////////
  // Narrow side outputs
  //////////////////////////////////////////////////

  // Miss data bypasses the buffer
  always_comb begin
    rd_word.flat = rd_pend ? wbm_dat_i : rbuf.flat;
  end

  assign wbs_dat_o = rd_word.lane[lane];

  // Hit acks at once, non-final write lanes a cycle later,
  // everything else follows the wide ack
  assign wbs_ack_o = (idle & req & !wbs_we_i & rbuf_hit) |
                     (wr_gath & wr_ack_q) |
                     ((rd_pend | wr_pend) & wbm_ack_i);

  assign wbs_err_o = (rd_pend | wr_pend) & wbm_err_i;

  //////////////////////////////////////////////////
  // Wide side outputs
  //////////////////////////////////////////////////

  assign wbm_adr_o = {wadr_q, {wb_upsizer_pkg::WIDE_SHIFT{1'b0}}};
  assign wbm_dat_o = wbuf.flat;
  // Reads always fetch the full word
  assign wbm_sel_o = wr_pend ? wsel : '1;
  assign wbm_we_o  = wr_pend;
  assign wbm_cyc_o = rd_pend | wr_pend;
  assign wbm_stb_o = rd_pend | wr_pend;
  // Every wide access is a single beat
  assign wbm_cti_o = wb_upsizer_pkg::CTI_EOB;
  assign wbm_bte_o = wb_upsizer_pkg::BTE_LINEAR;

  //////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_pend  <= 1'b0;
      wr_pend  <= 1'b0;
      wr_gath  <= 1'b0;
      wr_ack_q <= 1'b0;
      wr_first <= 1'b0;
      rbuf_vld <= 1'b0;
    end else begin
      // Gather ack is a single pulse
      wr_ack_q <= 1'b0;

      // Read miss goes out on the next cycle
      if (rd_miss) begin
        rd_pend <= 1'b1;
      end
      // Error leaves the buffer invalid
      if (rd_pend & (wbm_ack_i | wbm_err_i)) begin
        rd_pend  <= 1'b0;
        rbuf_vld <= wbm_ack_i;
      end

      if (wr_capture) begin
        wr_first <= 1'b0;
        // Keep reads coherent with the written word
        if (rbuf_hit) begin
          rbuf_vld <= 1'b0;
        end
        if (last_in_batch) begin
          wr_gath <= 1'b0;
          wr_pend <= 1'b1;
        end else begin
          wr_gath  <= 1'b1;
          wr_ack_q <= 1'b1;
        end
      end else if (wr_gath & !wbs_cyc_i) begin
        // Master dropped the cycle mid batch
        wr_gath  <= 1'b0;
        wr_first <= 1'b0;
      end

      if (wr_pend & wbm_ack_i) begin
        wr_pend <= 1'b0;
        // Burst goes on with a fresh batch
        if (!last_beat) begin
          wr_gath  <= 1'b1;
          wr_first <= 1'b1;
        end
      end
      if (wr_pend & wbm_err_i) begin
        wr_pend  <= 1'b0;
        rbuf_vld <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Buffers and wide address
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (rd_miss) begin
      wadr_q <= cur_wadr;
    end
    // Fill the buffer from the wide read
    if (rd_pend & wbm_ack_i) begin
      rbuf.flat <= wbm_dat_i;
      rbuf_adr  <= wadr_q;
    end

    if (wr_capture) begin
      // First beat of a batch clears the other lanes
      if (idle | wr_first) begin
        wsel <= '0;
      end
      if (idle) begin
        wadr_q <= cur_wadr;
      end
      wbuf.lane[lane] <= wbs_dat_i;
      wsel[lane]      <= wbs_sel_i;
    end

    // Next batch word comes from the burst stepping
    if (wr_pend & wbm_ack_i & !last_beat) begin
      wadr_q <= next_wide_adr[wb_upsizer_pkg::AW-wb_upsizer_pkg::WIDE_SHIFT-1:0];
    end
  end

endmodule

//--- logic/wb_upsizer_pkg.sv
package wb_upsizer_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Narrow side word and the upsizing ratio
  localparam int DW_IN        = 32;
  localparam int SCALE        = 2;
  localparam int DW_OUT       = DW_IN * SCALE;
  localparam int SEL_IN       = DW_IN / 8;
  localparam int SEL_OUT      = DW_OUT / 8;
  // Byte addressed on both sides
  localparam int AW           = 32;
  localparam int LANE_BITS    = 1;
  localparam int NARROW_SHIFT = 2;
  localparam int WIDE_SHIFT   = NARROW_SHIFT + LANE_BITS;
  // Depth of the wide memory in 64-bit words
  localparam int RAM_WORDS    = 256;

  //////////////////////////////////////////////////
  // Wishbone registered feedback codes
  //////////////////////////////////////////////////

  localparam logic [2:0] CTI_CLASSIC = 3'b000;
  localparam logic [2:0] CTI_INCR    = 3'b010;
  localparam logic [2:0] CTI_EOB     = 3'b111;

  localparam logic [1:0] BTE_LINEAR  = 2'b00;
  localparam logic [1:0] BTE_WRAP4   = 2'b01;
  localparam logic [1:0] BTE_WRAP8   = 2'b10;
  localparam logic [1:0] BTE_WRAP16  = 2'b11;

  // Wide word, seen flat or as narrow lanes
  typedef union packed {
    logic [DW_OUT-1:0]           flat;
    logic [SCALE-1:0][DW_IN-1:0] lane;
  } wide_word_u;

  // Next beat address of an incrementing burst
  function automatic logic [AW-1:0] next_adr(input logic [AW-1:0] adr,
                                             input logic [2:0]    cti,
                                             input logic [1:0]    bte,
                                             input int unsigned   dw_bytes);
    logic [AW-1:0] line_mask;
    logic [AW-1:0] inc_adr;
    // Bytes inside one wrap line, all ones for linear
    case (bte)
      BTE_WRAP4:  line_mask = AW'(4 * dw_bytes - 1);
      BTE_WRAP8:  line_mask = AW'(8 * dw_bytes - 1);
      BTE_WRAP16: line_mask = AW'(16 * dw_bytes - 1);
      default:    line_mask = '1;
    endcase
    inc_adr = adr + AW'(dw_bytes);
    // Only incrementing bursts move on
    if (cti == CTI_INCR) begin
      next_adr = (adr & ~line_mask) | (inc_adr & line_mask);
    end else begin
      next_adr = adr;
    end
  endfunction

endpackage

//--- logic/wb_upsizer_sys.sv
`timescale 1ns/10ps

module wb_upsizer_sys (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  // Narrow slave port
  input  logic [wb_upsizer_pkg::AW-1:0]     wbs_adr_i,
  input  logic [wb_upsizer_pkg::DW_IN-1:0]  wbs_dat_i,
  input  logic [wb_upsizer_pkg::SEL_IN-1:0] wbs_sel_i,
  input  logic                              wbs_we_i,
  input  logic                              wbs_cyc_i,
  input  logic                              wbs_stb_i,
  input  logic [2:0]                        wbs_cti_i,
  input  logic [1:0]                        wbs_bte_i,
  output logic [wb_upsizer_pkg::DW_IN-1:0]  wbs_dat_o,
  output logic                              wbs_ack_o,
  output logic                              wbs_err_o
);

  //////////////////////////////////////////////////
  // Wide bus
  //////////////////////////////////////////////////

  logic [wb_upsizer_pkg::AW-1:0]      wide_adr;
  logic [wb_upsizer_pkg::DW_OUT-1:0]  wide_dat_wr;
  logic [wb_upsizer_pkg::DW_OUT-1:0]  wide_dat_rd;
  logic [wb_upsizer_pkg::SEL_OUT-1:0] wide_sel;
  logic                               wide_we;
  logic                               wide_cyc;
  logic                               wide_stb;
  logic                               wide_ack;
  logic                               wide_err;

  wb_upsizer u_upsizer (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cti_i (wbs_cti_i),
    .wbs_bte_i (wbs_bte_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .wbs_err_o (wbs_err_o),
    .wbm_adr_o (wide_adr),
    .wbm_dat_o (wide_dat_wr),
    .wbm_sel_o (wide_sel),
    .wbm_we_o  (wide_we),
    .wbm_cyc_o (wide_cyc),
    .wbm_stb_o (wide_stb),
    // Memory answers every beat alike
    .wbm_cti_o (),
    .wbm_bte_o (),
    .wbm_dat_i (wide_dat_rd),
    .wbm_ack_i (wide_ack),
    .wbm_err_i (wide_err)
  );

  wb_wide_ram u_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .adr_i    (wide_adr),
    .dat_i    (wide_dat_wr),
    .sel_i    (wide_sel),
    .we_i     (wide_we),
    .cyc_i    (wide_cyc),
    .stb_i    (wide_stb),
    .dat_o    (wide_dat_rd),
    .ack_o    (wide_ack),
    .err_o    (wide_err)
  );

endmodule

//--- logic/wb_wide_ram.sv
`timescale 1ns/10ps

module wb_wide_ram (
  input  logic                               wb_clk_i,
  input  logic                               wb_rst_i,
  input  logic [wb_upsizer_pkg::AW-1:0]      adr_i,
  input  logic [wb_upsizer_pkg::DW_OUT-1:0]  dat_i,
  input  logic [wb_upsizer_pkg::SEL_OUT-1:0] sel_i,
  input  logic                               we_i,
  input  logic                               cyc_i,
  input  logic                               stb_i,
  output logic [wb_upsizer_pkg::DW_OUT-1:0]  dat_o,
  output logic                               ack_o,
  output logic                               err_o
);

  // Storage, one wide word per entry
  logic [wb_upsizer_pkg::DW_OUT-1:0] mem [wb_upsizer_pkg::RAM_WORDS];

  // Word address of the access
  logic [wb_upsizer_pkg::AW-wb_upsizer_pkg::WIDE_SHIFT-1:0] word_adr;
  logic [$clog2(wb_upsizer_pkg::RAM_WORDS)-1:0]             idx;
  logic                                                     in_range;
  logic                                                     req;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  assign word_adr = adr_i[wb_upsizer_pkg::AW-1:wb_upsizer_pkg::WIDE_SHIFT];
  assign in_range = word_adr < wb_upsizer_pkg::RAM_WORDS;
  assign idx      = word_adr[$clog2(wb_upsizer_pkg::RAM_WORDS)-1:0];

  // Gap cycle after every response
  assign req = cyc_i & stb_i & !ack_o & !err_o;

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      ack_o <= req & in_range;
      // Beyond the last word
      err_o <= req & !in_range;
    end
  end

  //////////////////////////////////////////////////
  // Storage access
  //////////////////////////////////////////////////

  // Byte lanes written under their select
  always_ff @(posedge wb_clk_i) begin
    if (req & we_i & in_range) begin
      for (int b = 0; b < wb_upsizer_pkg::SEL_OUT; b++) begin
        if (sel_i[b]) begin
          mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
        end
      end
    end
  end

  // Read data lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (req & !we_i & in_range) begin
      dat_o <= mem[idx];
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the wb_upsizer_sys testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module wb_upsizer_sys_tb -Mdir obj_dir -f wb_upsizer_sys.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vwb_upsizer_sys_tb +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- testbench/wb_upsizer_sys_props.sv
`timescale 1ns/10ps

module wb_upsizer_sys_props (
  input logic clk_i,
  input logic rst_i,
  // Narrow port
  input logic wbs_cyc_i,
  input logic wbs_stb_i,
  input logic wbs_ack_i,
  input logic wbs_err_i,
  // Wide port
  input logic wbm_cyc_i,
  input logic wbm_stb_i,
  input logic wbm_ack_i,
  input logic wbm_err_i
);

  // Failed assertions so far
  int fail_cnt = 0;

  // Narrow response only to a live request
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (wbs_ack_i | wbs_err_i) |-> (wbs_cyc_i & wbs_stb_i))
    else begin
      $error("narrow ack or err outside a request");
      fail_cnt++;
    end

  // Same on the wide side
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (wbm_ack_i | wbm_err_i) |-> (wbm_cyc_i & wbm_stb_i))
    else begin
      $error("wide ack or err outside a request");
      fail_cnt++;
    end

  // One response kind per beat
  assert property (@(posedge clk_i) disable iff (rst_i)
                   !((wbs_ack_i & wbs_err_i) | (wbm_ack_i & wbm_err_i)))
    else begin
      $error("ack and err high together");
      fail_cnt++;
    end

  // Wide request held inside its cycle until the RAM answers
  assert property (@(posedge clk_i) disable iff (rst_i)
                   (wbm_stb_i & !(wbm_ack_i | wbm_err_i)) |=> (wbm_stb_i & wbm_cyc_i))
    else begin
      $error("wide stb or cyc dropped before ack or err");
      fail_cnt++;
    end

  // Wide bus quiet right after reset
  assert property (@(posedge clk_i) rst_i |=> !wbm_cyc_i)
    else begin
      $error("wide cyc high in the cycle after reset");
      fail_cnt++;
    end

endmodule

bind wb_upsizer_sys wb_upsizer_sys_props u_props (
  .clk_i     (wb_clk_i),
  .rst_i     (wb_rst_i),
  .wbs_cyc_i (wbs_cyc_i),
  .wbs_stb_i (wbs_stb_i),
  .wbs_ack_i (wbs_ack_o),
  .wbs_err_i (wbs_err_o),
  .wbm_cyc_i (wide_cyc),
  .wbm_stb_i (wide_stb),
  .wbm_ack_i (wide_ack),
  .wbm_err_i (wide_err)
);

//--- testbench/wb_upsizer_sys_tb.sv
`timescale 1ns/10ps

module wb_upsizer_sys_tb;

  //////////////////////////////////////////////////
  // Constants and signals
  //////////////////////////////////////////////////

  localparam int ACK_LIMIT      = 20;
  // Three times about 90 beats of at most ACK_LIMIT + 2 cycles
  localparam int TIMEOUT_CYCLES = 6000;
  localparam int RAM_BYTES      = wb_upsizer_pkg::RAM_WORDS * 8;

  logic                              wb_clk_i;
  logic                              wb_rst_i;
  logic [wb_upsizer_pkg::AW-1:0]     wbs_adr_i;
  logic [wb_upsizer_pkg::DW_IN-1:0]  wbs_dat_i;
  logic [wb_upsizer_pkg::SEL_IN-1:0] wbs_sel_i;
  logic                              wbs_we_i;
  logic                              wbs_cyc_i;
  logic                              wbs_stb_i;
  logic [2:0]                        wbs_cti_i;
  logic [1:0]                        wbs_bte_i;
  logic [wb_upsizer_pkg::DW_IN-1:0]  wbs_dat_o;
  logic                              wbs_ack_o;
  logic                              wbs_err_o;

  // Byte image of the wide RAM with little endian lanes
  logic [7:0] model_mem [RAM_BYTES];

  int seed;
  int errors;
  int checks;
  int tests;
  int total;
  int cycles = 0;

  // Outcome of the latest beat
  logic [31:0] beat_dat;
  logic        beat_err;
  int          beat_waits;
  time         beat_time;

  wb_upsizer_sys dut_i (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_sel_i (wbs_sel_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cti_i (wbs_cti_i),
    .wbs_bte_i (wbs_bte_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .wbs_err_o (wbs_err_o)
  );

  // 4 ns clock
  initial wb_clk_i = 1'b0;
  always #2 wb_clk_i = ~wb_clk_i;

  // Run limit
  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing the tests", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic void model_write(input logic [31:0] adr, input logic [31:0] dat,
                                      input logic [3:0] sel);
    int base;
    base = int'({adr[31:2], 2'b00});
    // Above the RAM nothing changes
    if (base < RAM_BYTES) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) begin
          model_mem[base + b] = dat[b*8 +: 8];
        end
      end
    end
  endfunction

  function automatic logic [31:0] model_read(input logic [31:0] adr);
    logic [31:0] word;
    int          base;
    base = int'({adr[31:2], 2'b00});
    for (int b = 0; b < 4; b++) begin
      word[b*8 +: 8] = model_mem[base + b];
    end
    return word;
  endfunction

  // Beat i of a burst; wrap given in narrow beats and 0 for linear
  function automatic logic [31:0] beat_adr(input logic [31:0] start, input int i,
                                           input int wrap);
    logic [31:0] line;
    if (wrap == 0) begin
      return start + 32'(4 * i);
    end
    line = 32'(4 * wrap - 1);
    return (start & ~line) | ((start + 32'(4 * i)) & line);
  endfunction

  // Bench errors plus failed bus assertions
  function automatic int fail_count();
    return errors + dut_i.u_props.fail_cnt;
  endfunction

  //////////////////////////////////////////////////
  // Narrow master tasks
  //////////////////////////////////////////////////

  // One beat; cyc stays up when more beats follow
  task automatic bus_beat(input logic [31:0] adr, input logic we, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [2:0] cti,
                          input logic [1:0] bte, input logic more);
    int   waits;
    logic answered;
    waits     = 0;
    wbs_adr_i = adr;
    wbs_we_i  = we;
    wbs_dat_i = dat;
    wbs_sel_i = sel;
    wbs_cti_i = cti;
    wbs_bte_i = bte;
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    // Mid-cycle sampling once outputs have settled
    @(negedge wb_clk_i);
    while (!(wbs_ack_o | wbs_err_o) && waits < ACK_LIMIT) begin
      waits++;
      @(negedge wb_clk_i);
    end
    answered   = wbs_ack_o | wbs_err_o;
    beat_dat   = wbs_dat_o;
    beat_err   = wbs_err_o;
    beat_waits = waits;
    beat_time  = $time;
    assert (answered)
      else begin
        $display("no ack or err within %0d cycles for address %h", ACK_LIMIT, adr);
        errors++;
      end
    @(posedge wb_clk_i);
    #1;
    // Close the cycle and leave one idle cycle between transfers
    if (!more || !answered) begin
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
      @(posedge wb_clk_i);
      #1;
    end
  endtask

  task automatic write_beat(input logic [31:0] adr, input logic [31:0] dat,
                            input logic [3:0] sel, input logic [2:0] cti,
                            input logic [1:0] bte, input logic more);
    bus_beat(adr, 1'b1, dat, sel, cti, bte, more);
    assert (!beat_err)
      else begin
        $display("write to %h ended with err instead of ack", adr);
        errors++;
      end
    model_write(adr, dat, sel);
  endtask

  task automatic read_beat(input logic [31:0] adr, input logic [2:0] cti,
                           input logic [1:0] bte, input logic more);
    logic [31:0] exp;
    exp = model_read(adr);
    bus_beat(adr, 1'b0, '0, '1, cti, bte, more);
    checks++;
    assert (!beat_err)
      else begin
        $display("read from %h ended with err instead of ack", adr);
        errors++;
      end
    assert (beat_dat === exp)
      else begin
        $display("mismatch at %0t: wbs_dat_o got %h expected %h", beat_time, beat_dat, exp);
        errors++;
      end
  endtask

  // Classic access above the RAM
  task automatic error_beat(input logic [31:0] adr, input logic we);
    bus_beat(adr, we, 32'($random(seed)), '1, wb_upsizer_pkg::CTI_CLASSIC,
             wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    checks++;
    assert (beat_err)
      else begin
        $display("access to %h above the RAM got ack instead of err", adr);
        errors++;
      end
  endtask

  task automatic burst(input logic we, input logic [31:0] start, input int beats,
                       input logic [1:0] bte, input int wrap, input logic want_hits);
    logic [31:0] adr;
    logic [2:0]  cti;
    for (int i = 0; i < beats; i++) begin
      adr = beat_adr(start, i, wrap);
      cti = (i == beats - 1) ? wb_upsizer_pkg::CTI_EOB : wb_upsizer_pkg::CTI_INCR;
      if (we) begin
        write_beat(adr, 32'($random(seed)), '1, cti, bte, i != beats - 1);
      end else begin
        read_beat(adr, cti, bte, i != beats - 1);
        // Upper lane comes straight from the read buffer
        if (want_hits && adr[2]) begin
          assert (beat_waits == 0)
            else begin
              $display("read of %h waited %0d cycles, read buffer not used", adr, beat_waits);
              errors++;
            end
        end
      end
    end
  endtask

  task automatic end_test(input string name, input int errs_at_start);
    tests++;
    $display("test %0d %s: %s", tests, name,
             (fail_count() == errs_at_start) ? "ok" : "failed");
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic classic_test();
    int e;
    e = fail_count();
    write_beat(32'h0, 32'($random(seed)), '1, wb_upsizer_pkg::CTI_CLASSIC,
               wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    write_beat(32'h4, 32'($random(seed)), '1, wb_upsizer_pkg::CTI_CLASSIC,
               wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    read_beat(32'h0, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    read_beat(32'h4, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end_test("classic lanes", e);
  endtask

  task automatic partial_test();
    int e;
    int off;
    e = fail_count();
    // Known contents first, then byte merges
    for (int i = 0; i < 8; i++) begin
      write_beat(32'h300 + 32'(4 * i), 32'($random(seed)), '1,
                 wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      off = int'($unsigned($random(seed)) % 8);
      write_beat(32'h300 + 32'(4 * off), 32'($random(seed)), 4'($random(seed)),
                 wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      read_beat(32'h300 + 32'(4 * i), wb_upsizer_pkg::CTI_CLASSIC,
                wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end
    end_test("partial selects", e);
  endtask

  task automatic error_test();
    int e;
    e = fail_count();
    read_beat(32'h0, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    error_beat(32'h800, 1'b0);
    // Must go to the RAM again
    read_beat(32'h0, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    assert (beat_waits > 0)
      else begin
        $display("read of 0 after err was served from a stale read buffer");
        errors++;
      end
    // Word 256 aliases word 0 in the index bits
    error_beat(32'h800, 1'b1);
    error_beat(32'h804, 1'b1);
    read_beat(32'h0, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    read_beat(32'h4, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end_test("out of range", e);
  endtask

  task automatic coherent_test();
    int e;
    e = fail_count();
    read_beat(32'h100, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    write_beat(32'h100, 32'($random(seed)), '1, wb_upsizer_pkg::CTI_CLASSIC,
               wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    read_beat(32'h100, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    read_beat(32'h104, wb_upsizer_pkg::CTI_CLASSIC, wb_upsizer_pkg::BTE_LINEAR, 1'b0);
    end_test("buffer coherence", e);
  endtask

  initial begin
    int e;
    seed      = 32'hb456_c510;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    wbs_adr_i = '0;
    wbs_dat_i = '0;
    wbs_sel_i = '0;
    wbs_we_i  = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_stb_i = 1'b0;
    wbs_cti_i = wb_upsizer_pkg::CTI_CLASSIC;
    wbs_bte_i = wb_upsizer_pkg::BTE_LINEAR;
    wb_rst_i  = 1'b1;
    repeat (8) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    @(posedge wb_clk_i);
    #1;

    classic_test();
    e = fail_count();
    burst(1'b1, 32'h100, 8, wb_upsizer_pkg::BTE_LINEAR, 0, 1'b0);
    burst(1'b0, 32'h100, 8, wb_upsizer_pkg::BTE_LINEAR, 0, 1'b1);
    end_test("incrementing burst", e);
    partial_test();
    // Wrap bursts entered mid-line
    e = fail_count();
    burst(1'b1, 32'h204, 4, wb_upsizer_pkg::BTE_WRAP4, 4, 1'b0);
    burst(1'b0, 32'h204, 4, wb_upsizer_pkg::BTE_WRAP4, 4, 1'b0);
    burst(1'b1, 32'h21c, 8, wb_upsizer_pkg::BTE_WRAP8, 8, 1'b0);
    burst(1'b0, 32'h21c, 8, wb_upsizer_pkg::BTE_WRAP8, 8, 1'b0);
    end_test("wrapping burst", e);
    error_test();
    coherent_test();

    total = fail_count();
    $display("tests %0d, read checks %0d, errors %0d", tests, checks, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- wb_upsizer_sys.f
logic/wb_upsizer_pkg.sv
logic/wb_burst_adr.sv
logic/wb_upsizer.sv
logic/wb_wide_ram.sv
logic/wb_upsizer_sys.sv
testbench/wb_upsizer_sys_props.sv
testbench/wb_upsizer_sys_tb.sv
